/* include/flip_params.svh */
`ifndef FLIP_PARAMS_SVH
`define FLIP_PARAMS_SVH

// frame geometry
`define CHANNEL_WIDTH       16
`define SUBFRAME_WIDTH      8

// element widths
`define EST_ERROR_PRECISION 8
`define ENER_BITWIDTH       8

// flip pattern table shape
`define NUM_FLIP_PATTERNS   4
`define FLIP_PATTERN_DEPTH  3

// frames kept beyond the newest one
`define HISTORY_DEPTH       2
`define ALIGN_OFFSET        8
`define OUTPUT_PIPE_DEPTH   1

`define FLIP_COUNT_WIDTH    ($clog2(`CHANNEL_WIDTH + 1))

`endif

/* src/flip_pkg.sv */
`default_nettype none

`include "flip_params.svh"

package flip_pkg;

    // zero is no flag, k selects pattern k-1
    typedef logic [$clog2(`NUM_FLIP_PATTERNS + 1)-1:0] flag_t;
    typedef logic [`ENER_BITWIDTH-1:0]                 ener_t;
    typedef logic signed [`EST_ERROR_PRECISION-1:0]    res_t;

    typedef logic  [`CHANNEL_WIDTH-1:0] bits_frame_t;
    typedef res_t  [`CHANNEL_WIDTH-1:0] res_frame_t;
    typedef flag_t [`CHANNEL_WIDTH-1:0] flag_frame_t;
    typedef ener_t [`CHANNEL_WIDTH-1:0] ener_frame_t;

    typedef struct packed {
        bits_frame_t bits;
        res_frame_t  res;
        flag_frame_t flags;
        ener_frame_t ener;
    } rx_frame_t;

    typedef struct packed {
        bits_frame_t bits;
        res_frame_t  res;
        bits_frame_t flips;
    } corr_frame_t;

    // bit 0 lands on the flagged lane itself
    localparam logic [`FLIP_PATTERN_DEPTH-1:0] flip_patterns [`NUM_FLIP_PATTERNS] = '{
        3'b010, 3'b011, 3'b111, 3'b101
    };

endpackage : flip_pkg

`default_nettype wire

/* src/frame_history.sv */
`default_nettype none

module frame_history #(
    parameter type frame_t = logic,
    parameter int  DEPTH   = 2
) (
    input  logic   clk,
    input  logic   rst_n_i,
    input  frame_t frame_i,
    output frame_t history_o [0:DEPTH]
);

    frame_t history_q [0:DEPTH];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int k = 0; k <= DEPTH; k++) begin
                history_q[k] <= '0;
            end
        end else begin
            history_q[0] <= frame_i;
            // older entries move one slot down
            for (int k = 1; k <= DEPTH; k++) begin
                history_q[k] <= history_q[k-1];
            end
        end
    end

    // index 0 is the newest frame
    always_comb begin
        for (int k = 0; k <= DEPTH; k++) begin
            history_o[k] = history_q[k];
        end
    end

endmodule : frame_history

`default_nettype wire

/* src/frame_aligner.sv */
`default_nettype none

`include "flip_params.svh"

module frame_aligner #(
    parameter type elem_t    = logic,
    parameter int  DEPTH     = 2,
    parameter int  ALIGN_POS = 8
) (
    input  elem_t [(DEPTH+1)*`CHANNEL_WIDTH-1:0] flat_i,
    output elem_t [`CHANNEL_WIDTH-1:0]           aligned_o
);

    localparam int FLAT_LANES = (DEPTH + 1) * `CHANNEL_WIDTH;

    // window must stay inside the flattened history
    localparam int LAST_LANE = (ALIGN_POS + `CHANNEL_WIDTH <= FLAT_LANES) ?
                               ALIGN_POS + `CHANNEL_WIDTH - 1 : FLAT_LANES - 1;

    always_comb begin
        aligned_o = '0;
        for (int lane = 0; lane < `CHANNEL_WIDTH; lane++) begin
            if (ALIGN_POS + lane <= LAST_LANE) begin
                aligned_o[lane] = flat_i[ALIGN_POS + lane];
            end
        end
    end

endmodule : frame_aligner

`default_nettype wire

/* src/subframe_flip_locator.sv */
`default_nettype none

`include "flip_params.svh"

module subframe_flip_locator (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  flip_pkg::flag_frame_t flags_i,
    input  flip_pkg::ener_frame_t ener_i,
    output flip_pkg::bits_frame_t flips_o
);

    import flip_pkg::*;

    localparam int NUM_SUBFRAMES = `CHANNEL_WIDTH / `SUBFRAME_WIDTH;

    bits_frame_t flips_d;
    bits_frame_t flips_q;

    always_comb begin
        logic                           found;
        ener_t                          best_ener;
        flag_t                          best_flag;
        int                             best_lane;
        int                             lane;
        int                             pat_idx;
        logic [`FLIP_PATTERN_DEPTH-1:0] pattern;

        flips_d = '0;
        for (int s = 0; s < NUM_SUBFRAMES; s++) begin
            found     = 1'b0;
            best_ener = '0;
            best_flag = '0;
            best_lane = 0;
            // strict compare keeps the lowest lane on a tie
            for (int l = 0; l < `SUBFRAME_WIDTH; l++) begin
                lane = s * `SUBFRAME_WIDTH + l;
                if (flags_i[lane] != '0 && (!found || ener_i[lane] < best_ener)) begin
                    found     = 1'b1;
                    best_ener = ener_i[lane];
                    best_flag = flags_i[lane];
                    best_lane = lane;
                end
            end

            pat_idx = int'(best_flag) - 1;
            pattern = '0;
            if (found && pat_idx < `NUM_FLIP_PATTERNS) begin
                pattern = flip_patterns[pat_idx];
            end

            // OR into the mask, drop anything past the last lane
            for (int d = 0; d < `FLIP_PATTERN_DEPTH; d++) begin
                if (pattern[d] && best_lane + d < `CHANNEL_WIDTH) begin
                    flips_d[best_lane + d] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            flips_q <= '0;
        end else begin
            flips_q <= flips_d;
        end
    end

    assign flips_o = flips_q;

endmodule : subframe_flip_locator

`default_nettype wire

/* src/flip_bit_locator_datapath.sv */
`default_nettype none

`include "flip_params.svh"

module flip_bit_locator_datapath (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  flip_pkg::rx_frame_t   rx_frame_i,
    output flip_pkg::bits_frame_t bits_o,
    output flip_pkg::res_frame_t  res_o,
    output flip_pkg::bits_frame_t flips_o
);

    import flip_pkg::*;

    localparam int HIST_LANES = (`HISTORY_DEPTH + 1) * `CHANNEL_WIDTH;

    typedef struct packed {
        bits_frame_t bits;
        res_frame_t  res;
        bits_frame_t flips;
    } dp_frame_t;

    bits_frame_t bits_hist [0:`HISTORY_DEPTH];
    res_frame_t  res_hist  [0:`HISTORY_DEPTH];
    flag_frame_t flag_hist [0:`HISTORY_DEPTH];
    ener_frame_t ener_hist [0:`HISTORY_DEPTH];

    logic  [HIST_LANES-1:0] bits_flat;
    res_t  [HIST_LANES-1:0] res_flat;
    flag_t [HIST_LANES-1:0] flag_flat;
    ener_t [HIST_LANES-1:0] ener_flat;

    bits_frame_t bits_aligned;
    res_frame_t  res_aligned;
    flag_frame_t flag_window;
    ener_frame_t ener_window;
    bits_frame_t flips;

    bits_frame_t bits_q;
    res_frame_t  res_q;
    dp_frame_t   pipe_q [`OUTPUT_PIPE_DEPTH];

    frame_history #(.frame_t(bits_frame_t), .DEPTH(`HISTORY_DEPTH)) u_bits_hist (
        .clk(clk), .rst_n_i(rst_n_i), .frame_i(rx_frame_i.bits), .history_o(bits_hist)
    );
    frame_history #(.frame_t(res_frame_t), .DEPTH(`HISTORY_DEPTH)) u_res_hist (
        .clk(clk), .rst_n_i(rst_n_i), .frame_i(rx_frame_i.res), .history_o(res_hist)
    );
    frame_history #(.frame_t(flag_frame_t), .DEPTH(`HISTORY_DEPTH)) u_flag_hist (
        .clk(clk), .rst_n_i(rst_n_i), .frame_i(rx_frame_i.flags), .history_o(flag_hist)
    );
    frame_history #(.frame_t(ener_frame_t), .DEPTH(`HISTORY_DEPTH)) u_ener_hist (
        .clk(clk), .rst_n_i(rst_n_i), .frame_i(rx_frame_i.ener), .history_o(ener_hist)
    );

    // oldest frame lands in the low lanes
    for (genvar k = 0; k <= `HISTORY_DEPTH; k++) begin : g_flat
        assign bits_flat[k*`CHANNEL_WIDTH +: `CHANNEL_WIDTH] = bits_hist[`HISTORY_DEPTH - k];
        assign res_flat[k*`CHANNEL_WIDTH +: `CHANNEL_WIDTH]  = res_hist[`HISTORY_DEPTH - k];
        assign flag_flat[k*`CHANNEL_WIDTH +: `CHANNEL_WIDTH] = flag_hist[`HISTORY_DEPTH - k];
        assign ener_flat[k*`CHANNEL_WIDTH +: `CHANNEL_WIDTH] = ener_hist[`HISTORY_DEPTH - k];
    end

    frame_aligner #(.elem_t(logic), .DEPTH(`HISTORY_DEPTH), .ALIGN_POS(`ALIGN_OFFSET))
        u_bits_aligner (.flat_i(bits_flat), .aligned_o(bits_aligned));
    frame_aligner #(.elem_t(res_t), .DEPTH(`HISTORY_DEPTH), .ALIGN_POS(`ALIGN_OFFSET))
        u_res_aligner (.flat_i(res_flat), .aligned_o(res_aligned));

    assign flag_window = flag_flat[`ALIGN_OFFSET +: `CHANNEL_WIDTH];
    assign ener_window = ener_flat[`ALIGN_OFFSET +: `CHANNEL_WIDTH];

    subframe_flip_locator u_locator (
        .clk(clk), .rst_n_i(rst_n_i), .flags_i(flag_window), .ener_i(ener_window),
        .flips_o(flips)
    );

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            bits_q <= '0;
            res_q  <= '0;
            for (int k = 0; k < `OUTPUT_PIPE_DEPTH; k++) begin
                pipe_q[k] <= '0;
            end
        end else begin
            // matches the locator register
            bits_q    <= bits_aligned;
            res_q     <= res_aligned;
            pipe_q[0] <= '{bits: bits_q, res: res_q, flips: flips};
            for (int k = 1; k < `OUTPUT_PIPE_DEPTH; k++) begin
                pipe_q[k] <= pipe_q[k-1];
            end
        end
    end

    assign bits_o  = pipe_q[`OUTPUT_PIPE_DEPTH-1].bits;
    assign res_o   = pipe_q[`OUTPUT_PIPE_DEPTH-1].res;
    assign flips_o = pipe_q[`OUTPUT_PIPE_DEPTH-1].flips;

endmodule : flip_bit_locator_datapath

`default_nettype wire

/* src/bit_corrector.sv */
`default_nettype none

`include "flip_params.svh"

module bit_corrector (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  flip_pkg::bits_frame_t        bits_i,
    input  flip_pkg::res_frame_t         res_i,
    input  flip_pkg::bits_frame_t        flips_i,
    output flip_pkg::corr_frame_t        corr_frame_o,
    output logic [`FLIP_COUNT_WIDTH-1:0] flip_count_o
);

    import flip_pkg::*;

    localparam int CW = `FLIP_COUNT_WIDTH;

    logic [CW-1:0] count_d;
    corr_frame_t   corr_q;
    logic [CW-1:0] count_q;

    always_comb begin
        count_d = '0;
        for (int lane = 0; lane < `CHANNEL_WIDTH; lane++) begin
            count_d = count_d + CW'(flips_i[lane]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            corr_q  <= '0;
            count_q <= '0;
        end else begin
            corr_q  <= '{bits: bits_i ^ flips_i, res: res_i, flips: flips_i};
            count_q <= count_d;
        end
    end

    assign corr_frame_o = corr_q;
    assign flip_count_o = count_q;

endmodule : bit_corrector

`default_nettype wire

/* src/error_correction_top.sv */
`default_nettype none

`include "flip_params.svh"

module error_correction_top (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  flip_pkg::rx_frame_t          rx_frame_i,
    output flip_pkg::corr_frame_t        corr_frame_o,
    output logic [`FLIP_COUNT_WIDTH-1:0] flip_count_o
);

    import flip_pkg::*;

    bits_frame_t dp_bits;
    res_frame_t  dp_res;
    bits_frame_t dp_flips;

    // window bits, residuals and flip mask arrive together
    flip_bit_locator_datapath u_datapath (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .rx_frame_i(rx_frame_i),
        .bits_o    (dp_bits),
        .res_o     (dp_res),
        .flips_o   (dp_flips)
    );

    bit_corrector u_corrector (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .bits_i      (dp_bits),
        .res_i       (dp_res),
        .flips_i     (dp_flips),
        .corr_frame_o(corr_frame_o),
        .flip_count_o(flip_count_o)
    );

endmodule : error_correction_top

`default_nettype wire

/* verif/tb_clk_gen.sv */
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS = 40
) (
    output logic clk_o
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
    end

    always begin
        #(PERIOD_NS / 2);
        clk_o = ~clk_o;
    end

endmodule : tb_clk_gen

`default_nettype wire

/* verif/tb_error_correction.sv */
`default_nettype none

`include "flip_params.svh"

module tb_error_correction;

    timeunit 1ns;
    timeprecision 100ps;

    import flip_pkg::*;

    localparam int NUM_ROWS       = 24;
    localparam int NUM_DIRECTED   = 13;
    localparam int RESET_CYCLES   = 8;
    localparam int DRIVE_DELAY    = 2;
    localparam int PIPE_LATENCY   = 3;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_ROWS + 10;

    typedef logic [`FLIP_COUNT_WIDTH-1:0] count_t;

    typedef struct packed {
        rx_frame_t   stim;
        corr_frame_t exp_corr;
        count_t      exp_count;
    } table_row_t;

    // pattern k-1 for flag k, bit 0 on the flagged lane
    localparam logic [2:0] PATTERNS [4] = '{3'b010, 3'b011, 3'b111, 3'b101};

    logic        clk;
    logic        rst_n;
    rx_frame_t   rx_frame;
    corr_frame_t corr_frame;
    count_t      flip_count;

    table_row_t  vectors [NUM_ROWS];
    int          cycle_count = 0;

    tb_clk_gen #(.PERIOD_NS(40)) u_clk_gen (.clk_o(clk));

    error_correction_top UUT (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .rx_frame_i  (rx_frame),
        .corr_frame_o(corr_frame),
        .flip_count_o(flip_count)
    );

    // frames before the first row and after the last are all zero
    function automatic rx_frame_t frame_at(input int idx);
        if (idx < 0 || idx >= NUM_ROWS) begin
            return '0;
        end
        return vectors[idx].stim;
    endfunction

    // window of frame m starts at stream lane (m-2)*16 + ALIGN_OFFSET
    function automatic void model_window(input int m, output corr_frame_t corr,
                                         output count_t cnt);
        rx_frame_t   src;
        bits_frame_t w_bits;
        res_frame_t  w_res;
        flag_t       w_flag [`CHANNEL_WIDTH];
        ener_t       w_ener [`CHANNEL_WIDTH];
        bits_frame_t flips;
        logic [2:0]  pat;
        int          fidx;
        int          lane;
        int          best;

        flips = '0;
        cnt   = '0;
        for (int l = 0; l < `CHANNEL_WIDTH; l++) begin
            fidx      = m - 2 + (`ALIGN_OFFSET + l) / `CHANNEL_WIDTH;
            lane      = (`ALIGN_OFFSET + l) % `CHANNEL_WIDTH;
            src       = frame_at(fidx);
            w_bits[l] = src.bits[lane];
            w_res[l]  = src.res[lane];
            w_flag[l] = src.flags[lane];
            w_ener[l] = src.ener[lane];
        end
        for (int s = 0; s < `CHANNEL_WIDTH / `SUBFRAME_WIDTH; s++) begin
            best = -1;
            for (int l = s * `SUBFRAME_WIDTH; l < (s + 1) * `SUBFRAME_WIDTH; l++) begin
                if (w_flag[l] != '0 && (best < 0 || w_ener[l] < w_ener[best])) begin
                    best = l;
                end
            end
            if (best >= 0) begin
                pat = PATTERNS[int'(w_flag[best]) - 1];
                for (int d = 0; d < 3; d++) begin
                    if (pat[d] && best + d < `CHANNEL_WIDTH) begin
                        flips[best + d] = 1'b1;
                    end
                end
            end
        end
        for (int l = 0; l < `CHANNEL_WIDTH; l++) begin
            cnt = cnt + count_t'(flips[l]);
        end
        corr.bits  = w_bits ^ flips;
        corr.res   = w_res;
        corr.flips = flips;
    endfunction

    task automatic place_flag(input int row, input int lane, input flag_t flag,
                              input ener_t ener);
        vectors[row].stim.flags[lane] = flag;
        vectors[row].stim.ener[lane]  = ener;
    endtask

    task automatic build_table();
        corr_frame_t corr;
        count_t      cnt;

        for (int r = 0; r < NUM_DIRECTED; r++) begin
            vectors[r]           = '0;
            vectors[r].stim.bits = bits_frame_t'(16'h9c5a ^ (r * 16'h0b37));
            for (int l = 0; l < `CHANNEL_WIDTH; l++) begin
                vectors[r].stim.res[l]  = res_t'(r * 11 + l * 7 - 64);
                vectors[r].stim.ener[l] = ener_t'(200 + l);
            end
        end
        // rows 0 and 1 carry no flags
        place_flag(2, 9, 3'd1, 8'd40);
        place_flag(3, 12, 3'd2, 8'd40);
        place_flag(4, 8, 3'd3, 8'd40);
        place_flag(5, 14, 3'd4, 8'd40);
        place_flag(6, 2, 3'd3, 8'd40);
        // minimum energy, then a tie broken by the lower lane
        place_flag(7, 9, 3'd1, 8'd50);
        place_flag(7, 11, 3'd2, 8'd20);
        place_flag(7, 13, 3'd3, 8'd90);
        place_flag(8, 10, 3'd4, 8'd30);
        place_flag(8, 12, 3'd2, 8'd30);
        place_flag(8, 15, 3'd1, 8'd40);
        // both subframes overlap on window lane 8
        place_flag(9, 14, 3'd3, 8'd10);
        place_flag(10, 0, 3'd2, 8'd5);
        place_flag(10, 7, 3'd3, 8'd100);
        // patterns running past window lane 15
        place_flag(11, 7, 3'd3, 8'd10);
        place_flag(12, 6, 3'd4, 8'd10);

        for (int r = NUM_DIRECTED; r < NUM_ROWS; r++) begin
            vectors[r]           = '0;
            vectors[r].stim.bits = bits_frame_t'($urandom);
            for (int l = 0; l < `CHANNEL_WIDTH; l++) begin
                vectors[r].stim.res[l]  = res_t'($urandom);
                vectors[r].stim.ener[l] = ener_t'($urandom % 16);
                if ($urandom % 3 == 0) begin
                    vectors[r].stim.flags[l] = flag_t'(1 + $urandom % 4);
                end
            end
        end

        for (int r = 0; r < NUM_ROWS; r++) begin
            model_window(r, corr, cnt);
            vectors[r].exp_corr  = corr;
            vectors[r].exp_count = cnt;
        end
    endtask

    task automatic check_corr(input corr_frame_t got, input corr_frame_t expected,
                              input int frame_idx);
        if (got !== expected) begin
            $display("FAILED at %0t: frame %0d corrected frame got %h expected %h",
                     $time, frame_idx, got, expected);
            $display("Verification failed");
            $fatal(1, "corrected frame mismatch");
        end
    endtask

    task automatic check_count(input count_t got, input count_t expected, input int frame_idx);
        if (got !== expected) begin
            $display("FAILED at %0t: frame %0d flip count got %0d expected %0d",
                     $time, frame_idx, got, expected);
            $display("Verification failed");
            $fatal(1, "flip count mismatch");
        end
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Verification failed");
            $fatal(1, "timeout: the run went past %0d clock cycles", TIMEOUT_CYCLES);
        end
    end

    initial begin
        corr_frame_t expected_corr;
        count_t      expected_count;
        int          m;

        rst_n    = 1'b0;
        rx_frame = '0;
        void'($urandom(32'ha414));
        build_table();

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n    = 1'b1;
        rx_frame = vectors[0].stim;

        // two extra frames flush the last rows out of the window
        for (int c = 0; c < NUM_ROWS + PIPE_LATENCY + 2; c++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            m = c - PIPE_LATENCY;
            if (m >= 0 && m < NUM_ROWS) begin
                expected_corr  = vectors[m].exp_corr;
                expected_count = vectors[m].exp_count;
            end else begin
                model_window(m, expected_corr, expected_count);
            end
            check_corr(corr_frame, expected_corr, m);
            check_count(flip_count, expected_count, m);
            rx_frame = (c + 1 < NUM_ROWS) ? vectors[c + 1].stim : '0;
        end

        $display("Verification passed");
        $finish;
    end

endmodule : tb_error_correction

`default_nettype wire

/* compile.f */
+incdir+include
src/flip_pkg.sv
src/frame_history.sv
src/frame_aligner.sv
src/subframe_flip_locator.sv
src/flip_bit_locator_datapath.sv
src/bit_corrector.sv
src/error_correction_top.sv
verif/tb_clk_gen.sv
verif/tb_error_correction.sv

/* Makefile */
TOP := tb_error_correction

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): compile.f $(wildcard src/*.sv verif/*.sv include/*.svh)
	verilator --binary --timing -Wno-fatal -f compile.f --top-module $(TOP) -o V$(TOP)

lint:
	verilator --lint-only --timing -Wall -f compile.f --top-module error_correction_top

clean:
	rm -rf obj_dir
